/* rtl/data_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module data_ram #(
    parameter int fast_words = 256
) (
    input  logic               clk,
    input  logic               en,
    input  lsu_pkg::ram_req_t  req,
    output lsu_pkg::word_t     rdata
);
    import lsu_pkg::*;

    localparam int idx_w = $clog2(fast_words);

    word_t             mem [fast_words];
    logic [idx_w-1:0]  idx;

    assign idx = req.word_idx[idx_w-1:0];

    // rdata holds until the next access
    always_ff @(posedge clk) begin
        if (en) begin
            if (req.write) begin
                mem[idx] <= req.data;
            end else begin
                rdata <= mem[idx];
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/ls_ex.sv */
`timescale 1ns/1ps
`default_nettype none

module ls_ex #(
    parameter int fast_words = 256
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               rdy,
    input  logic               req_en,
    input  lsu_pkg::ls_req_t   req,
    input  logic               rollback,
    output logic               busy,
    output logic               result_valid,
    output lsu_pkg::word_t     result,
    output logic               mc_en,
    output lsu_pkg::mc_req_t   mc_req,
    input  logic               mc_done,
    input  lsu_pkg::word_t     mc_rdata,
    output logic               dr_en,
    output lsu_pkg::ram_req_t  dr_req,
    input  lsu_pkg::word_t     dr_rdata
);
    import lsu_pkg::*;

    localparam int idx_w = $clog2(fast_words);

    typedef enum logic [2:0] {
        st_idle,
        st_slow_load,
        st_slow_store,
        st_fast_wait,
        st_fast_load,
        st_fast_store
    } state_e;

    state_e                 state;
    ls_op_e                 cur_op;
    logic                   kill;
    logic [fast_words-1:0]  shadow;
    logic                   in_fast;
    logic [idx_w-1:0]       widx;

    function automatic logic is_store(ls_op_e op);
        return (op == op_sb) || (op == op_sh) || (op == op_sw);
    endfunction

    function automatic logic [2:0] op_size(ls_op_e op);
        case (op)
            op_lb, op_lbu, op_sb: return 3'd1;
            op_lh, op_lhu, op_sh: return 3'd2;
            default:              return 3'd4;
        endcase
    endfunction

    // sign or zero extension of the returned bytes
    function automatic word_t extend(ls_op_e op, word_t d);
        case (op)
            op_lb:   return {{24{d[7]}}, d[7:0]};
            op_lh:   return {{16{d[15]}}, d[15:0]};
            op_lbu:  return {24'b0, d[7:0]};
            op_lhu:  return {16'b0, d[15:0]};
            default: return d;
        endcase
    endfunction

    assign in_fast = {2'b00, req.addr[31:2]} < 32'(fast_words);
    assign widx    = req.addr[idx_w+1:2];
    assign busy    = (state != st_idle) || req_en;

    always_ff @(posedge clk) begin
        if (rst) begin
            state        <= st_idle;
            cur_op       <= op_nop;
            kill         <= 1'b0;
            shadow       <= '0;
            result_valid <= 1'b0;
            mc_en        <= 1'b0;
            dr_en        <= 1'b0;
        end else if (rdy) begin
            result_valid <= 1'b0;
            mc_en        <= 1'b0;
            dr_en        <= 1'b0;
            case (state)
                st_idle: begin
                    if (req_en && req.op != op_nop) begin
                        cur_op <= req.op;
                        kill   <= 1'b0;
                        if (req.op == op_sw && in_fast) begin
                            // word now lives in the fast RAM
                            dr_en        <= 1'b1;
                            dr_req       <= '{word_idx: {2'b00, req.addr[31:2]},
                                              data: req.data, write: 1'b1};
                            shadow[widx] <= 1'b1;
                            state        <= st_fast_store;
                        end else if (req.op == op_lw && in_fast && shadow[widx]) begin
                            dr_en  <= 1'b1;
                            dr_req <= '{word_idx: {2'b00, req.addr[31:2]},
                                        data: req.data, write: 1'b0};
                            state  <= st_fast_wait;
                        end else begin
                            mc_en  <= 1'b1;
                            mc_req <= '{addr: req.addr, data: req.data,
                                        write: is_store(req.op), size: op_size(req.op)};
                            state  <= is_store(req.op) ? st_slow_store : st_slow_load;
                        end
                    end
                end
                st_slow_load: begin
                    if (mc_done) begin
                        if (!kill && !rollback) begin
                            result_valid <= 1'b1;
                            result       <= extend(cur_op, mc_rdata);
                        end
                        state <= st_idle;
                    end else if (rollback) begin
                        kill <= 1'b1;
                    end
                end
                // stores finish even across a rollback
                st_slow_store: begin
                    if (mc_done) begin
                        state <= st_idle;
                    end
                end
                st_fast_wait: begin
                    if (rollback) begin
                        kill <= 1'b1;
                    end
                    state <= st_fast_load;
                end
                st_fast_load: begin
                    if (!kill && !rollback) begin
                        result_valid <= 1'b1;
                        result       <= extend(cur_op, dr_rdata);
                    end
                    state <= st_idle;
                end
                st_fast_store: begin
                    state <= st_idle;
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // only one memory path is started at a time
    a_one_path: assert property (@(posedge clk) disable iff (rst) !(mc_en && dr_en));

    a_no_store_result: assert property (@(posedge clk) disable iff (rst)
        result_valid |-> !is_store(cur_op));

endmodule

`default_nettype wire

/* rtl/lsu_pkg.sv */
`default_nettype none

package lsu_pkg;

    typedef logic [31:0] word_t;

    typedef enum logic [3:0] {
        op_nop = 4'd0,
        op_lb  = 4'd1,
        op_lh  = 4'd2,
        op_lw  = 4'd3,
        op_lbu = 4'd4,
        op_lhu = 4'd5,
        op_sb  = 4'd6,
        op_sh  = 4'd7,
        op_sw  = 4'd8
    } ls_op_e;

    // one operation handed to ls_ex
    typedef struct packed {
        ls_op_e      op;
        logic [31:0] addr;
        word_t       data;
    } ls_req_t;

    // byte-serial controller request, size in bytes
    typedef struct packed {
        logic [31:0] addr;
        word_t       data;
        logic        write;
        logic [2:0]  size;
    } mc_req_t;

    // fast data RAM request, word_idx is cut down by the RAM
    typedef struct packed {
        logic [31:0] word_idx;
        word_t       data;
        logic        write;
    } ram_req_t;

endpackage

`default_nettype wire

/* rtl/lsu_top.sv */
`timescale 1ns/1ps
`default_nettype none

module lsu_top #(
    parameter int main_addr_w = 12,
    parameter int fast_words  = 256
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              rdy,
    input  logic              req_en,
    input  lsu_pkg::ls_req_t  req,
    input  logic              rollback,
    output logic              busy,
    output logic              result_valid,
    output lsu_pkg::word_t    result
);
    import lsu_pkg::*;

    logic                    mc_en;
    mc_req_t                 mc_req;
    logic                    mc_done;
    word_t                   mc_rdata;
    logic                    dr_en;
    ram_req_t                dr_req;
    word_t                   dr_rdata;
    logic [main_addr_w-1:0]  mem_addr;
    logic [7:0]              mem_wdata;
    logic                    mem_we;
    logic [7:0]              mem_rdata;

    ls_ex #(
        .fast_words(fast_words)
    ) u_ls_ex (
        .clk          (clk),
        .rst          (rst),
        .rdy          (rdy),
        .req_en       (req_en),
        .req          (req),
        .rollback     (rollback),
        .busy         (busy),
        .result_valid (result_valid),
        .result       (result),
        .mc_en        (mc_en),
        .mc_req       (mc_req),
        .mc_done      (mc_done),
        .mc_rdata     (mc_rdata),
        .dr_en        (dr_en),
        .dr_req       (dr_req),
        .dr_rdata     (dr_rdata)
    );

    // slow path
    mem_ctrl #(
        .main_addr_w(main_addr_w)
    ) u_mem_ctrl (
        .clk       (clk),
        .rst       (rst),
        .rdy       (rdy),
        .mc_en     (mc_en),
        .mc_req    (mc_req),
        .mc_done   (mc_done),
        .mc_rdata  (mc_rdata),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_we    (mem_we),
        .mem_rdata (mem_rdata)
    );

    main_ram #(
        .main_addr_w(main_addr_w)
    ) u_main_ram (
        .clk   (clk),
        .addr  (mem_addr),
        .wdata (mem_wdata),
        .we    (mem_we),
        .rdata (mem_rdata)
    );

    // fast path
    data_ram #(
        .fast_words(fast_words)
    ) u_data_ram (
        .clk   (clk),
        .en    (dr_en),
        .req   (dr_req),
        .rdata (dr_rdata)
    );

endmodule

`default_nettype wire

/* rtl/main_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module main_ram #(
    parameter int main_addr_w = 12
) (
    input  logic                    clk,
    input  logic [main_addr_w-1:0]  addr,
    input  logic [7:0]              wdata,
    input  logic                    we,
    output logic [7:0]              rdata
);

    logic [7:0] mem [2**main_addr_w];

    // read returns the old byte on a same-cycle write
    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
        rdata <= mem[addr];
    end

endmodule

`default_nettype wire

/* rtl/mem_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_ctrl #(
    parameter int main_addr_w = 12
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    rdy,
    input  logic                    mc_en,
    input  lsu_pkg::mc_req_t        mc_req,
    output logic                    mc_done,
    output lsu_pkg::word_t          mc_rdata,
    output logic [main_addr_w-1:0]  mem_addr,
    output logic [7:0]              mem_wdata,
    output logic                    mem_we,
    input  logic [7:0]              mem_rdata
);
    import lsu_pkg::*;

    logic                    active;
    logic                    wr;
    logic [2:0]              size;
    logic [main_addr_w-1:0]  base;
    word_t                   wdata;
    word_t                   rbuf;
    logic [1:0]              cnt;
    logic [1:0]              rd_idx;
    logic                    rd_vld;
    logic                    last;

    assign last = ({1'b0, cnt} == size - 3'd1);

    // on a stall keep reading the byte still in flight
    assign mem_addr  = base + main_addr_w'((rd_vld && !rdy) ? rd_idx : cnt);
    assign mem_wdata = wdata[{cnt, 3'b000} +: 8];
    assign mem_we    = active && wr && rdy;

    // last byte comes straight from the RAM in the done cycle
    always_comb begin
        mc_rdata = rbuf;
        if (rd_vld) begin
            mc_rdata[{rd_idx, 3'b000} +: 8] = mem_rdata;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            active  <= 1'b0;
            mc_done <= 1'b0;
            rd_vld  <= 1'b0;
            cnt     <= 2'd0;
        end else if (rdy) begin
            mc_done <= 1'b0;
            rd_vld  <= 1'b0;
            if (rd_vld) begin
                rbuf[{rd_idx, 3'b000} +: 8] <= mem_rdata;
            end
            if (mc_en) begin
                active <= 1'b1;
                wr     <= mc_req.write;
                size   <= mc_req.size;
                base   <= mc_req.addr[main_addr_w-1:0];
                wdata  <= mc_req.data;
                cnt    <= 2'd0;
                rbuf   <= '0;
            end else if (active) begin
                if (!wr) begin
                    rd_vld <= 1'b1;
                    rd_idx <= cnt;
                end
                cnt <= cnt + 2'd1;
                if (last) begin
                    active  <= 1'b0;
                    mc_done <= 1'b1;
                end
            end
        end
    end

    a_no_overlap: assert property (@(posedge clk) disable iff (rst)
        (mc_en && rdy) |-> !active);

    a_legal_size: assert property (@(posedge clk) disable iff (rst)
        mc_en |-> (mc_req.size inside {3'd1, 3'd2, 3'd4}));

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -j 0 --top-module tb_lsu -f src.f
./obj_dir/Vtb_lsu

/* src.f */
rtl/lsu_pkg.sv
rtl/ls_ex.sv
rtl/mem_ctrl.sv
rtl/main_ram.sv
rtl/data_ram.sv
rtl/lsu_top.sv
test/tb_lsu.sv

/* test/tb_lsu.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_lsu;
    import lsu_pkg::*;

    localparam int main_addr_w = 12;
    localparam int fast_words  = 256;
    localparam int limit       = 100;

    logic     clk;
    logic     rst;
    logic     rdy;
    logic     req_en;
    ls_req_t  req;
    logic     rollback;
    logic     busy;
    logic     result_valid;
    word_t    result;

    // mirrors of main memory, data RAM and shadow bits
    logic [7:0] main_model [2**main_addr_w];
    word_t      fast_model [fast_words];
    logic       shadow_model [fast_words];

    lsu_top #(
        .main_addr_w(main_addr_w),
        .fast_words (fast_words)
    ) u_dut (
        .clk          (clk),
        .rst          (rst),
        .rdy          (rdy),
        .req_en       (req_en),
        .req          (req),
        .rollback     (rollback),
        .busy         (busy),
        .result_valid (result_valid),
        .result       (result)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("*** TEST FAILED ***");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            abort_run($sformatf("ERR %0t %s got %h expected %h", $time, name, got, exp));
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            abort_run($sformatf("ERR %0t %s got %b expected %b", $time, name, got, exp));
        end
    endtask

    task automatic check_idle();
        check_bit("result_valid", result_valid, 1'b0);
    endtask

    function automatic logic [main_addr_w-1:0] maddr(logic [31:0] addr);
        return addr[main_addr_w-1:0];
    endfunction

    function automatic logic [7:0] model_byte(logic [31:0] addr);
        return main_model[maddr(addr)];
    endfunction

    function automatic word_t expect_load(ls_op_e op, logic [31:0] addr);
        int          widx;
        logic [7:0]  b;
        logic [15:0] h;
        widx = int'(addr >> 2);
        b    = model_byte(addr);
        h    = {model_byte(addr + 32'd1), b};
        if (op == op_lw && widx < fast_words && shadow_model[widx]) begin
            return fast_model[widx];
        end
        case (op)
            op_lb:   return 32'($signed(b));
            op_lh:   return 32'($signed(h));
            op_lbu:  return 32'(b);
            op_lhu:  return 32'(h);
            default: return {model_byte(addr + 32'd3), model_byte(addr + 32'd2), h};
        endcase
    endfunction

    task automatic wait_idle();
        int n;
        n = 0;
        @(negedge clk);
        while (busy) begin
            check_idle();
            n++;
            if (n > limit) begin
                abort_run("timeout: busy never dropped");
            end
            @(negedge clk);
        end
        check_idle();
    endtask

    task automatic wait_result(output word_t data);
        int n;
        n = 0;
        @(negedge clk);
        while (!result_valid) begin
            n++;
            if (n > limit) begin
                abort_run("timeout: no load result arrived");
            end
            @(negedge clk);
        end
        data = result;
    endtask

    task automatic issue(input ls_op_e op, input logic [31:0] addr, input word_t data);
        @(posedge clk);
        req_en <= 1'b1;
        req    <= '{op: op, addr: addr, data: data};
        @(posedge clk);
        req_en <= 1'b0;
    endtask

    task automatic do_store(input ls_op_e op, input logic [31:0] addr, input word_t data,
                            input logic roll);
        int widx;
        int nbytes;
        widx   = int'(addr >> 2);
        nbytes = (op == op_sb) ? 1 : (op == op_sh) ? 2 : 4;
        if (op == op_sw && widx < fast_words) begin
            fast_model[widx]   = data;
            shadow_model[widx] = 1'b1;
        end else begin
            for (int k = 0; k < nbytes; k++) begin
                main_model[maddr(addr + 32'(k))] = data[8*k +: 8];
            end
        end
        issue(op, addr, data);
        if (roll) begin
            rollback <= 1'b1;
            @(posedge clk);
            rollback <= 1'b0;
        end
        wait_idle();
    endtask

    task automatic do_load(input ls_op_e op, input logic [31:0] addr, input logic roll,
                           input int stall);
        word_t got;
        word_t exp;
        exp = expect_load(op, addr);
        issue(op, addr, 32'd0);
        if (roll) begin
            rollback <= 1'b1;
            @(posedge clk);
            rollback <= 1'b0;
        end else begin
            if (stall > 0) begin
                @(posedge clk);
                rdy <= 1'b0;
                repeat (stall) @(posedge clk);
                rdy <= 1'b1;
            end
            wait_result(got);
            check_word("result", got, exp);
        end
        // a second pulse or a cancelled result shows up here
        wait_idle();
    endtask

    task automatic check_fast_timing(input logic [31:0] addr);
        word_t exp;
        exp = expect_load(op_lw, addr);
        issue(op_lw, addr, 32'd0);
        for (int i = 1; i <= 3; i++) begin
            @(negedge clk);
            check_bit("result_valid", result_valid, i == 3);
        end
        check_word("result", result, exp);
        wait_idle();
    endtask

    task automatic test_reset_unshadowed();
        check_bit("busy", busy, 1'b0);
        check_bit("result_valid", result_valid, 1'b0);
        check_bit("mc_en", u_dut.mc_en, 1'b0);
        check_bit("dr_en", u_dut.dr_en, 1'b0);
        for (int a = 0; a < 64; a++) begin
            do_store(op_sb, 32'(a), $urandom(), 1'b0);
            do_store(op_sb, 32'(2048 + a), $urandom(), 1'b0);
        end
        // fast region but never shadowed, so main memory answers
        do_load(op_lw, 32'd8, 1'b0, 0);
        do_load(op_lw, 32'd60, 1'b0, 0);
    endtask

    task automatic test_slow_sizes();
        do_store(op_sw, 32'd3072, 32'h80ff7f01, 1'b0);
        do_store(op_sw, 32'd3076, $urandom(), 1'b0);
        do_store(op_sh, 32'd3080, 32'h0000_8001, 1'b0);
        do_store(op_sh, 32'd3082, $urandom(), 1'b0);
        do_store(op_sb, 32'd3084, 32'h0000_00f0, 1'b0);
        for (int k = 1; k < 4; k++) begin
            do_store(op_sb, 32'(3084 + k), $urandom(), 1'b0);
        end
        for (int k = 0; k < 16; k++) begin
            do_load(op_lb, 32'(3072 + k), 1'b0, 0);
            do_load(op_lbu, 32'(3072 + k), 1'b0, 0);
        end
        for (int k = 0; k < 16; k += 2) begin
            do_load(op_lh, 32'(3072 + k), 1'b0, 0);
            do_load(op_lhu, 32'(3072 + k), 1'b0, 0);
        end
        for (int k = 0; k < 16; k += 4) begin
            do_load(op_lw, 32'(3072 + k), 1'b0, 0);
        end
    endtask

    task automatic test_fast_path();
        do_store(op_sw, 32'd16, $urandom(), 1'b0);
        check_fast_timing(32'd16);
        do_store(op_sw, 32'd1020, $urandom(), 1'b0);
        check_fast_timing(32'd1020);
    endtask

    task automatic test_rollback();
        do_load(op_lw, 32'd2048, 1'b1, 0);
        do_load(op_lw, 32'd2048, 1'b0, 0);
        do_load(op_lb, 32'd2049, 1'b1, 0);
        do_load(op_lw, 32'd16, 1'b1, 0);
        do_load(op_lw, 32'd16, 1'b0, 0);
        // stores ignore the rollback
        do_store(op_sw, 32'd2060, $urandom(), 1'b1);
        do_load(op_lw, 32'd2060, 1'b0, 0);
        do_store(op_sw, 32'd20, $urandom(), 1'b1);
        do_load(op_lw, 32'd20, 1'b0, 0);
        do_store(op_sh, 32'd2070, $urandom(), 1'b1);
        do_load(op_lhu, 32'd2070, 1'b0, 0);
    endtask

    task automatic test_stall();
        for (int i = 0; i < 4; i++) begin
            do_load(op_lw, 32'd2048, 1'b0, int'($urandom_range(1, 8)));
            do_load(op_lw, 32'd16, 1'b0, int'($urandom_range(1, 8)));
        end
    endtask

    initial begin
        void'($urandom(48));
        rst      <= 1'b1;
        rdy      <= 1'b1;
        req_en   <= 1'b0;
        req      <= '0;
        rollback <= 1'b0;
        for (int i = 0; i < fast_words; i++) begin
            shadow_model[i] = 1'b0;
        end
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        test_reset_unshadowed();
        test_slow_sizes();
        test_fast_path();
        test_rollback();
        test_stall();
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire
